// File: hw/cpu_bus_if.sv
// ##################################################
// cpu bus request
// one access per cycle from the arbiter to all targets.
// ##################################################
`timescale 1ns/10ps
`default_nettype none

interface cpu_bus_if;
    import nes_bus_pkg::*;

    logic      req_valid;
    bus_addr_t req_addr;
    bus_data_t req_wdata;
    bus_op_e   req_op;

    modport master
    (
        output req_valid,
        output req_addr,
        output req_wdata,
        output req_op
    );

    modport target
    (
        input req_valid,
        input req_addr,
        input req_wdata,
        input req_op
    );

endinterface

`default_nettype wire

// File: hw/joypad_port.sv
// ##################################################
// joypad port
// strobe latch at $4016, pad reads at $4016/$4017.
// ##################################################
`timescale 1ns/10ps
`default_nettype none

module joypad_port
(
    input  wire                             i_clk,
    input  wire                             i_reset_n,
    input  wire [nes_bus_pkg::NUM_PADS-1:0] i_serial,
    cpu_bus_if.target                       bus,
    output logic                            o_strobe,
    output logic [nes_bus_pkg::NUM_PADS-1:0] o_shift,
    output nes_bus_pkg::bus_data_t          o_rdata
);
    import nes_bus_pkg::*;

    logic r_rd_bit;
    logic w_strobe_wr;

    assign w_strobe_wr = bus.req_valid && (bus.req_op == BUS_WRITE)
                         && (bus.req_addr == ADDR_JOY1);

    // pad i sits at $4016 + i.
    always_comb
    begin
        for (int i = 0; i < NUM_PADS; i++)
        begin
            o_shift[i] = bus.req_valid && (bus.req_op == BUS_READ)
                         && (bus.req_addr == bus_addr_t'(ADDR_JOY1 + i));
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_strobe <= 1'b0;
            r_rd_bit <= 1'b0;
        end
        else
        begin
            if (w_strobe_wr)
                o_strobe <= bus.req_wdata[0];
            // bit of the selected pad, taken before it shifts.
            r_rd_bit <= |(o_shift & i_serial);
        end
    end

    assign o_rdata = {{($bits(bus_data_t) - 1){1'b0}}, r_rd_bit};

endmodule

`default_nettype wire

// File: hw/joypad_shifter.sv
// ##################################################
// joypad shifter
// standard pad, 8 buttons out serially.
// ##################################################
`timescale 1ns/10ps
`default_nettype none

module joypad_shifter
(
    input  wire                         i_clk,
    input  wire                         i_strobe,
    input  wire                         i_shift,
    input  wire nes_bus_pkg::pad_buttons_t i_buttons,
    output logic                        o_serial
);
    import nes_bus_pkg::*;

    pad_buttons_t r_shift;

    always_ff @(posedge i_clk)
    begin
        if (i_strobe)
            r_shift <= i_buttons;
        else if (i_shift)
            r_shift <= {1'b1, r_shift[PAD_BITS-1:1]};   // ones after Right.
    end

    // while strobed the pad shows live A.
    assign o_serial = i_strobe ? i_buttons[0] : r_shift[0];

endmodule

`default_nettype wire

// File: hw/nes_bus_pkg.sv
// ##################################################
// nes cpu bus package
// bus types, register map, sizes and state enums.
// ##################################################
`default_nettype none

package nes_bus_pkg;

    typedef logic [15:0] bus_addr_t;
    typedef logic [7:0]  bus_data_t;

    // read is high, as on the 6502 r/w pin.
    typedef enum logic {
        BUS_WRITE = 1'b0,
        BUS_READ  = 1'b1
    } bus_op_e;

    typedef enum logic [1:0] {
        DMA_IDLE,
        DMA_START,
        DMA_READ,
        DMA_WRITE
    } dma_state_e;

    // bit 0 = A, then B, Select, Start, Up, Down, Left, Right.
    typedef logic [7:0] pad_buttons_t;

    localparam bus_addr_t ADDR_OAMADDR   = 16'h2003;
    localparam bus_addr_t ADDR_OAMDATA   = 16'h2004;
    localparam bus_addr_t ADDR_OAMDMA    = 16'h4014;
    localparam bus_addr_t ADDR_JOY1      = 16'h4016;
    localparam bus_addr_t ADDR_JOY2      = 16'h4017;
    localparam bus_addr_t RAM_MIRROR_END = 16'h1FFF;

    localparam int RAM_ADDR_W = 11;
    localparam int OAM_DEPTH  = 256;
    localparam int NUM_PADS   = 2;
    localparam int PAD_BITS   = 8;

endpackage

`default_nettype wire

// File: hw/nes_cpu_bus_top.sv
// ##################################################
// nes cpu bus top
// work ram, oam, oam dma and joypads on one cpu bus.
// ##################################################
`timescale 1ns/10ps
`default_nettype none

module nes_cpu_bus_top
(
    input  wire                         i_clk,
    input  wire                         i_reset_n,
    input  wire                         i_cpu_valid,
    input  wire nes_bus_pkg::bus_addr_t i_cpu_addr,
    input  wire nes_bus_pkg::bus_data_t i_cpu_wdata,
    input  wire nes_bus_pkg::bus_op_e   i_cpu_op,
    input  wire nes_bus_pkg::pad_buttons_t [nes_bus_pkg::NUM_PADS-1:0] i_pad_buttons,
    output nes_bus_pkg::bus_data_t      o_cpu_rdata,
    output logic                        o_cpu_stall,
    output logic                        o_pad_strobe
);
    import nes_bus_pkg::*;

    bus_data_t           w_ram_rdata;
    bus_data_t           w_oam_rdata;
    bus_data_t           w_pad_rdata;
    logic                w_pad_strobe;
    logic [NUM_PADS-1:0] w_pad_shift;
    logic [NUM_PADS-1:0] w_pad_serial;

    cpu_bus_if bus ();

    oam_dma_arbiter u_arbiter
    (
        .i_clk       (i_clk),
        .i_reset_n   (i_reset_n),
        .i_cpu_valid (i_cpu_valid),
        .i_cpu_addr  (i_cpu_addr),
        .i_cpu_wdata (i_cpu_wdata),
        .i_cpu_op    (i_cpu_op),
        .i_ram_rdata (w_ram_rdata),
        .i_oam_rdata (w_oam_rdata),
        .i_pad_rdata (w_pad_rdata),
        .bus         (bus),
        .o_cpu_rdata (o_cpu_rdata),
        .o_cpu_stall (o_cpu_stall)
    );

    work_ram u_work_ram
    (
        .i_clk   (i_clk),
        .bus     (bus),
        .o_rdata (w_ram_rdata)
    );

    oam_ram u_oam_ram
    (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .bus       (bus),
        .o_rdata   (w_oam_rdata)
    );

    joypad_port u_joypad_port
    (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_serial  (w_pad_serial),
        .bus       (bus),
        .o_strobe  (w_pad_strobe),
        .o_shift   (w_pad_shift),
        .o_rdata   (w_pad_rdata)
    );

    genvar g;
    generate
        for (g = 0; g < NUM_PADS; g++)
        begin : g_pad
            joypad_shifter u_pad
            (
                .i_clk     (i_clk),
                .i_strobe  (w_pad_strobe),
                .i_shift   (w_pad_shift[g]),
                .i_buttons (i_pad_buttons[g]),
                .o_serial  (w_pad_serial[g])
            );
        end
    endgenerate

    assign o_pad_strobe = w_pad_strobe;

endmodule

`default_nettype wire

// File: hw/oam_dma_arbiter.sv
// ##################################################
// oam dma arbiter
// picks cpu or dma as bus owner, runs the $4014 copy
// and returns merged read data to the cpu.
// ##################################################
`timescale 1ns/10ps
`default_nettype none

module oam_dma_arbiter
(
    input  wire                     i_clk,
    input  wire                     i_reset_n,
    input  wire                     i_cpu_valid,
    input  wire nes_bus_pkg::bus_addr_t i_cpu_addr,
    input  wire nes_bus_pkg::bus_data_t i_cpu_wdata,
    input  wire nes_bus_pkg::bus_op_e   i_cpu_op,
    input  wire nes_bus_pkg::bus_data_t i_ram_rdata,
    input  wire nes_bus_pkg::bus_data_t i_oam_rdata,
    input  wire nes_bus_pkg::bus_data_t i_pad_rdata,
    cpu_bus_if.master               bus,
    output nes_bus_pkg::bus_data_t  o_cpu_rdata,
    output logic                    o_cpu_stall
);
    import nes_bus_pkg::*;

    dma_state_e r_state;
    logic [7:0] r_dma_page;
    logic [7:0] r_dma_cnt;
    logic       r_cpu_rd_pending;
    bus_data_t  r_cpu_rdata;
    logic [9:0] r_dma_accesses;
    logic       w_cpu_go;
    logic       w_dma_trig;
    bus_data_t  w_rd_merged;

    assign w_cpu_go    = i_cpu_valid && (r_state == DMA_IDLE);
    assign w_dma_trig  = w_cpu_go && (i_cpu_op == BUS_WRITE) && (i_cpu_addr == ADDR_OAMDMA);
    // unselected targets return zero.
    assign w_rd_merged = i_ram_rdata | i_oam_rdata | i_pad_rdata;
    assign o_cpu_stall = (r_state != DMA_IDLE);

    always_comb
    begin
        bus.req_valid = 1'b0;
        bus.req_addr  = i_cpu_addr;
        bus.req_wdata = i_cpu_wdata;
        bus.req_op    = i_cpu_op;
        case (r_state)
        DMA_IDLE:
        begin
            // the $4014 write stays inside the arbiter.
            bus.req_valid = w_cpu_go && !w_dma_trig;
        end
        DMA_READ:
        begin
            bus.req_valid = 1'b1;
            bus.req_addr  = {r_dma_page, r_dma_cnt};
            bus.req_wdata = '0;
            bus.req_op    = BUS_READ;
        end
        DMA_WRITE:
        begin
            // ram returns the byte one cycle after the read.
            bus.req_valid = 1'b1;
            bus.req_addr  = ADDR_OAMDATA;
            bus.req_wdata = w_rd_merged;
            bus.req_op    = BUS_WRITE;
        end
        default:
        begin
            bus.req_addr  = '0;
        end
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_state    <= DMA_IDLE;
            r_dma_page <= '0;
            r_dma_cnt  <= '0;
        end
        else
        begin
            case (r_state)
            DMA_IDLE:
            begin
                if (w_dma_trig)
                begin
                    r_dma_page <= i_cpu_wdata;
                    r_state    <= DMA_START;
                end
            end
            DMA_START:
            begin
                r_dma_cnt <= '0;
                r_state   <= DMA_READ;
            end
            DMA_READ:
            begin
                r_state <= DMA_WRITE;
            end
            DMA_WRITE:
            begin
                r_dma_cnt <= r_dma_cnt + 8'd1;
                if (r_dma_cnt == 8'hff)
                    r_state <= DMA_IDLE;
                else
                    r_state <= DMA_READ;
            end
            default:
            begin
                r_state <= DMA_IDLE;
            end
            endcase
        end
    end

    // cpu read data, held until the next cpu read returns.
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_cpu_rd_pending <= 1'b0;
            r_cpu_rdata      <= '0;
        end
        else
        begin
            r_cpu_rd_pending <= w_cpu_go && (i_cpu_op == BUS_READ);
            if (r_cpu_rd_pending)
                r_cpu_rdata <= w_rd_merged;
        end
    end

    assign o_cpu_rdata = r_cpu_rd_pending ? w_rd_merged : r_cpu_rdata;

    // bus accesses made during one dma.
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            r_dma_accesses <= '0;
        else if (r_state == DMA_START)
            r_dma_accesses <= '0;
        else if (o_cpu_stall && bus.req_valid)
            r_dma_accesses <= r_dma_accesses + 10'd1;
    end

    // while stalled the bus carries only dma traffic.
    a_no_cpu_during_stall: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (o_cpu_stall && bus.req_valid) |->
            ((bus.req_op == BUS_READ) ? (bus.req_addr[15:8] == r_dma_page)
                                      : (bus.req_addr == ADDR_OAMDATA)));

    // one read and one write per byte, 256 bytes.
    a_dma_access_count: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        $fell(o_cpu_stall) |-> (r_dma_accesses == 10'd512));

endmodule

`default_nettype wire

// File: hw/oam_ram.sv
// ##################################################
// sprite attribute memory
// oamaddr at $2003, data port at $2004.
// ##################################################
`timescale 1ns/10ps
`default_nettype none

module oam_ram
(
    input  wire                     i_clk,
    input  wire                     i_reset_n,
    cpu_bus_if.target               bus,
    output nes_bus_pkg::bus_data_t  o_rdata
);
    import nes_bus_pkg::*;

    bus_data_t                    mem [0:OAM_DEPTH-1];
    logic [$clog2(OAM_DEPTH)-1:0] r_oam_addr;
    bus_data_t                    r_rd_data;
    logic                         r_rd_en;
    logic                         w_addr_wr;
    logic                         w_data_acc;

    assign w_addr_wr  = bus.req_valid && (bus.req_op == BUS_WRITE)
                        && (bus.req_addr == ADDR_OAMADDR);
    assign w_data_acc = bus.req_valid && (bus.req_addr == ADDR_OAMDATA);

    always_ff @(posedge i_clk)
    begin
        if (w_data_acc && (bus.req_op == BUS_WRITE))
            mem[r_oam_addr] <= bus.req_wdata;
        r_rd_data <= mem[r_oam_addr];
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_oam_addr <= '0;
            r_rd_en    <= 1'b0;
        end
        else
        begin
            if (w_addr_wr)
                r_oam_addr <= bus.req_wdata;
            else if (w_data_acc)
                r_oam_addr <= r_oam_addr + 1'b1;    // wraps at 256.
            r_rd_en <= w_data_acc && (bus.req_op == BUS_READ);
        end
    end

    assign o_rdata = r_rd_en ? r_rd_data : '0;

    // every data port access advances oamaddr, never a $2003 load.
    a_data_port_advances: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        w_data_acc |=> (r_oam_addr == $past(r_oam_addr) + 1'b1));

endmodule

`default_nettype wire

// File: hw/work_ram.sv
// ##################################################
// work ram
// 2 KB with registered read, mirrored to $1FFF.
// ##################################################
`timescale 1ns/10ps
`default_nettype none

module work_ram
(
    input  wire                     i_clk,
    cpu_bus_if.target               bus,
    output nes_bus_pkg::bus_data_t  o_rdata
);
    import nes_bus_pkg::*;

    bus_data_t             mem [0:(1 << RAM_ADDR_W) - 1];
    bus_data_t             r_rd_data;
    logic                  r_rd_en;
    logic                  w_sel;
    logic [RAM_ADDR_W-1:0] w_idx;

    assign w_sel = bus.req_valid && (bus.req_addr <= RAM_MIRROR_END);
    // upper address bits ignored, so the four mirrors alias.
    assign w_idx = bus.req_addr[RAM_ADDR_W-1:0];

    always_ff @(posedge i_clk)
    begin
        if (w_sel && (bus.req_op == BUS_WRITE))
            mem[w_idx] <= bus.req_wdata;
        r_rd_data <= mem[w_idx];
    end

    always_ff @(posedge i_clk)
    begin
        r_rd_en <= w_sel && (bus.req_op == BUS_READ);
    end

    assign o_rdata = r_rd_en ? r_rd_data : '0;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the NES CPU bus testbench with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_nes_cpu_bus -f src.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_nes_cpu_bus > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: src.f
hw/nes_bus_pkg.sv
hw/cpu_bus_if.sv
hw/oam_dma_arbiter.sv
hw/work_ram.sv
hw/oam_ram.sv
hw/joypad_shifter.sv
hw/joypad_port.sv
hw/nes_cpu_bus_top.sv
verif/tb_nes_cpu_bus.sv

// File: verif/tb_nes_cpu_bus.sv
// ##################################################
// nes cpu bus testbench
// ram mirrors, oam port, oam dma and joypads.
// ##################################################
`timescale 1ns/10ps
`default_nettype none

module tb_nes_cpu_bus;
    import nes_bus_pkg::*;

    // two dma runs plus about 1200 single accesses, with margin.
    localparam int TIMEOUT_CYCLES = 8000;
    localparam int DMA_STALL_LIMIT = 520;

    logic                              clk;
    logic                              reset_n;
    logic                              cpu_valid;
    bus_addr_t                         cpu_addr;
    bus_data_t                         cpu_wdata;
    bus_op_e                           cpu_op;
    pad_buttons_t [NUM_PADS-1:0]       pad_buttons;
    bus_data_t                         cpu_rdata;
    logic                              cpu_stall;
    logic                              pad_strobe;

    // reference state.
    bus_data_t    ram_model [0:(1 << RAM_ADDR_W) - 1];
    bus_data_t    oam_model [0:OAM_DEPTH-1];
    logic [7:0]   oam_addr_model;
    logic         strobe_model;
    pad_buttons_t pad_sh_model [0:NUM_PADS-1];

    bus_data_t    exp_q [$];
    string        name_q [$];
    int           due_q [$];
    int           cycle = 0;
    logic [15:0]  lfsr = 16'd27610;
    bus_addr_t    written_q [$];

    nes_cpu_bus_top DUT
    (
        .i_clk         (clk),
        .i_reset_n     (reset_n),
        .i_cpu_valid   (cpu_valid),
        .i_cpu_addr    (cpu_addr),
        .i_cpu_wdata   (cpu_wdata),
        .i_cpu_op      (cpu_op),
        .i_pad_buttons (pad_buttons),
        .o_cpu_rdata   (cpu_rdata),
        .o_cpu_stall   (cpu_stall),
        .o_pad_strobe  (pad_strobe)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            r = {r[14:0], lfsr[0]};
        end
        return r;
    endfunction

    // applies one accepted access to the model, returns the expected read byte.
    function automatic bus_data_t model_access(input bus_op_e op, input bus_addr_t addr,
                                               input bus_data_t wdata);
        bus_data_t rd;
        int        p;
        rd = '0;
        if (addr <= RAM_MIRROR_END)
        begin
            if (op == BUS_WRITE)
                ram_model[addr[RAM_ADDR_W-1:0]] = wdata;
            else
                rd = ram_model[addr[RAM_ADDR_W-1:0]];
        end
        else if (addr == ADDR_OAMADDR)
        begin
            if (op == BUS_WRITE)
                oam_addr_model = wdata;
        end
        else if (addr == ADDR_OAMDATA)
        begin
            if (op == BUS_WRITE)
                oam_model[oam_addr_model] = wdata;
            else
                rd = oam_model[oam_addr_model];
            oam_addr_model = oam_addr_model + 8'd1;
        end
        else if (addr == ADDR_OAMDMA && op == BUS_WRITE)
        begin
            for (int i = 0; i < OAM_DEPTH; i++)
                oam_model[8'(oam_addr_model + i)] = ram_model[11'({wdata, 8'(i)})];
        end
        else if (addr == ADDR_JOY1 && op == BUS_WRITE)
        begin
            // pads load on every edge seen with strobe high.
            if (strobe_model)
                for (int i = 0; i < NUM_PADS; i++)
                    pad_sh_model[i] = pad_buttons[i];
            strobe_model = wdata[0];
        end
        else if ((addr == ADDR_JOY1 || addr == ADDR_JOY2) && op == BUS_READ)
        begin
            p = int'(addr - ADDR_JOY1);
            if (strobe_model)
                rd = {7'b0, pad_buttons[p][0]};
            else
            begin
                rd = {7'b0, pad_sh_model[p][0]};
                pad_sh_model[p] = {1'b1, pad_sh_model[p][PAD_BITS-1:1]};
            end
        end
        return rd;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_data(input string name, input bus_data_t exp, input bus_data_t act);
        if (act !== exp)
        begin
            $display("MISMATCH %s: expected %02h, actual %02h", name, exp, act);
            abort_run("read data differs from the reference model");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
            abort_run("status flag differs from the expected value");
        end
    endtask

    // called 2 ns after a rising edge; repeats the request while stalled.
    task automatic bus_access(input bus_op_e op, input bus_addr_t addr,
                              input bus_data_t wdata, input string name);
        logic      accepted;
        bus_data_t exp;
        accepted = 1'b0;
        while (!accepted)
        begin
            cpu_valid = 1'b1;
            cpu_op    = op;
            cpu_addr  = addr;
            cpu_wdata = wdata;
            @(negedge clk);
            accepted = !cpu_stall;
            if (accepted)
            begin
                exp = model_access(op, addr, wdata);
                if (op == BUS_READ)
                begin
                    exp_q.push_back(exp);
                    name_q.push_back(name);
                    due_q.push_back(cycle + 1);
                end
            end
            @(posedge clk);
            #2;
        end
        cpu_valid = 1'b0;
    endtask

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES)
            abort_run("timeout, the run went past its cycle limit");
    end

    // read data is checked mid-cycle, one cycle after the access.
    always @(negedge clk)
    begin : compare
        bus_data_t exp;
        string     nm;
        if (due_q.size() > 0 && due_q[0] == cycle)
        begin
            exp = exp_q.pop_front();
            nm  = name_q.pop_front();
            void'(due_q.pop_front());
            check_data(nm, exp, cpu_rdata);
        end
    end

    task automatic run_dma(input logic [7:0] page);
        bus_data_t  start;
        bus_addr_t  probe;
        int         waited;
        for (int i = 0; i < 256; i++)
            bus_access(BUS_WRITE, {page, 8'(i)}, 8'(rand_bits(8)), "dma_fill");
        start = 8'(rand_bits(8));
        if (start == 8'h00)
            start = 8'h01;
        bus_access(BUS_WRITE, ADDR_OAMADDR, start, "dma_oamaddr");
        bus_access(BUS_WRITE, ADDR_OAMDMA, page, "dma_trigger");
        // a cpu write during the stall must be dropped.
        probe     = {page, 8'h07};
        cpu_valid = 1'b1;
        cpu_op    = BUS_WRITE;
        cpu_addr  = probe;
        cpu_wdata = ~ram_model[probe[RAM_ADDR_W-1:0]];
        @(negedge clk);
        check_flag("dma_stall_rise", 1'b1, cpu_stall);
        @(posedge clk);
        #2;
        cpu_valid = 1'b0;
        waited = 1;
        while (cpu_stall)
        begin
            @(posedge clk);
            #2;
            waited++;
            if (waited > DMA_STALL_LIMIT)
                abort_run("stall did not fall within 520 cycles of the dma trigger");
        end
        bus_access(BUS_WRITE, ADDR_OAMADDR, start, "dma_oamaddr_back");
        for (int i = 0; i < OAM_DEPTH; i++)
            bus_access(BUS_READ, ADDR_OAMDATA, '0, "dma_oam_copy");
        bus_access(BUS_READ, probe, '0, "dma_stalled_write");
    endtask

    initial
    begin
        logic [10:0] a;
        logic [1:0]  mirror;
        bus_data_t   start;
        reset_n     = 1'b0;
        cpu_valid   = 1'b0;
        cpu_addr    = '0;
        cpu_wdata   = '0;
        cpu_op      = BUS_READ;
        pad_buttons = '0;
        oam_addr_model = '0;
        strobe_model   = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        reset_n = 1'b1;
        @(negedge clk);
        check_flag("reset_stall", 1'b0, cpu_stall);
        check_flag("reset_strobe", 1'b0, pad_strobe);
        check_data("reset_rdata", 8'h00, cpu_rdata);
        @(posedge clk);
        #2;

        for (int i = 0; i < 48; i++)
        begin
            a = 11'(rand_bits(11));
            bus_access(BUS_WRITE, {5'b0, a}, 8'(rand_bits(8)), "ram_write");
            written_q.push_back({5'b0, a});
        end
        foreach (written_q[i])
        begin
            mirror = 2'(rand_bits(2));
            if (mirror == 2'b00)
                mirror = 2'b01;
            bus_access(BUS_READ, {3'b0, mirror, written_q[i][10:0]}, '0, "ram_mirror");
        end

        start = 8'(rand_bits(8));
        bus_access(BUS_WRITE, ADDR_OAMADDR, start, "oam_addr");
        for (int i = 0; i < 16; i++)
            bus_access(BUS_WRITE, ADDR_OAMDATA, 8'(rand_bits(8)), "oam_write");
        bus_access(BUS_WRITE, ADDR_OAMADDR, start, "oam_addr_again");
        for (int i = 0; i < 16; i++)
            bus_access(BUS_READ, ADDR_OAMDATA, '0, "oam_read");

        run_dma(8'h02);
        run_dma(8'h0D);

        for (int s = 0; s < 3; s++)
        begin
            pad_buttons[0] = 8'(rand_bits(8));
            pad_buttons[1] = 8'(rand_bits(8));
            bus_access(BUS_WRITE, ADDR_JOY1, 8'h01, "pad_strobe_on");
            check_flag("pad_strobe_high", 1'b1, pad_strobe);
            bus_access(BUS_READ, ADDR_JOY1, '0, "pad1_strobed");
            bus_access(BUS_WRITE, ADDR_JOY1, 8'h00, "pad_strobe_off");
            check_flag("pad_strobe_low", 1'b0, pad_strobe);
            for (int i = 0; i < 10; i++)
                bus_access(BUS_READ, ADDR_JOY1, '0, "pad1_serial");
            for (int i = 0; i < 10; i++)
                bus_access(BUS_READ, ADDR_JOY2, '0, "pad2_serial");
        end

        repeat (2) @(posedge clk);
        if (due_q.size() != 0)
            abort_run("run ended with reads left unchecked");
        else
        begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire
